// File: Makefile
# Verilator build and run for the decode-to-dispatch slice
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_decode_dispatch
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

# The exit status of the simulator is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_decode_dispatch.sv
`timescale 1ns/1ps

module tb_decode_dispatch;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_ROWS      = 16;
    localparam int RANDOM_CYCLES = 60;
    localparam int RUN_TIMEOUT   = 400;
    localparam int DRAIN_CYCLES  = 4;
    localparam int W             = core_pkg::DECODE_WIDTH;

    localparam logic [31:0] PC_BASE   = 32'h0000_1000;
    localparam logic [31:0] LFSR_SEED = 32'h7f4d_7b50;

    // Short names so the table rows stay readable
    localparam logic [5:0] ENC_ALU_RR = core_pkg::OPC_ALU_RR;
    localparam logic [5:0] ENC_ALU_RI = core_pkg::OPC_ALU_RI;
    localparam logic [5:0] ENC_MUL    = core_pkg::OPC_MUL;
    localparam logic [5:0] ENC_LOAD   = core_pkg::OPC_LOAD;
    localparam logic [5:0] ENC_STORE  = core_pkg::OPC_STORE;
    localparam logic [5:0] ENC_BRANCH = core_pkg::OPC_BRANCH;
    localparam core_pkg::op_class_e CLS_ALU = core_pkg::OP_ALU;
    localparam core_pkg::op_class_e CLS_MUL = core_pkg::OP_MUL;
    localparam core_pkg::op_class_e CLS_MEM = core_pkg::OP_MEM;
    localparam core_pkg::op_class_e CLS_BR  = core_pkg::OP_BRANCH;

    typedef struct packed {
        logic [core_pkg::OPCODE_WIDTH-1:0]  opc;
        logic [core_pkg::REG_IDX_WIDTH-1:0] rd;
        logic [core_pkg::REG_IDX_WIDTH-1:0] rj;
        logic [core_pkg::IMM_WIDTH-1:0]     imm;
        core_pkg::op_class_e                op_class;
        logic                               rd_we;
        logic [core_pkg::REG_IDX_WIDTH-1:0] rk;
        logic [1:0]                         src_use;  // {rj used, rk used}
    } row_t;

    logic clk;
    logic rst_n;
    logic stall_i;
    logic flush_i;
    logic alu_ready_i;
    logic mul_ready_i;
    logic mem_ready_i;
    core_pkg::instr_info_t [W-1:0] fetch_i;
    logic                  [W-1:0] accept_o;
    core_pkg::issue_t      [W-1:0] issue_o;

    row_t rows [NUM_ROWS];
    int   pending [$];
    int   lane_row [W];
    int   fetch_ptr;
    int   issued_cnt;
    int   cycle;
    logic [31:0] lfsr;

    // Values in force at the most recent clock edge
    core_pkg::issue_t [W-1:0] prev_issue;
    logic prev_stall;
    logic prev_flush;
    logic prev_alu_rdy;
    logic prev_mul_rdy;
    logic prev_mem_rdy;

    decode_dispatch_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .fetch_i     (fetch_i),
        .accept_o    (accept_o),
        .alu_ready_i (alu_ready_i),
        .mul_ready_i (mul_ready_i),
        .mem_ready_i (mem_ready_i),
        .issue_o     (issue_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_table();
        // opcode, rd, rj, imm, then expected class, rd_we, rk, source use
        rows[0]  = '{ENC_ALU_RR, 5'd3,  5'd1,  16'h1000, CLS_ALU, 1'b1, 5'd2,  2'b11};
        rows[1]  = '{ENC_ALU_RI, 5'd4,  5'd3,  16'h0010, CLS_ALU, 1'b1, 5'd0,  2'b10};
        rows[2]  = '{ENC_MUL,    5'd5,  5'd1,  16'h1000, CLS_MUL, 1'b1, 5'd2,  2'b11};
        rows[3]  = '{ENC_MUL,    5'd6,  5'd2,  16'h1800, CLS_MUL, 1'b1, 5'd3,  2'b11};
        rows[4]  = '{ENC_LOAD,   5'd7,  5'd1,  16'h0040, CLS_MEM, 1'b1, 5'd0,  2'b10};
        rows[5]  = '{ENC_STORE,  5'd6,  5'd2,  16'h0044, CLS_MEM, 1'b0, 5'd6,  2'b11};
        rows[6]  = '{ENC_BRANCH, 5'd4,  5'd5,  16'hfff8, CLS_BR,  1'b0, 5'd4,  2'b11};
        rows[7]  = '{ENC_ALU_RI, 5'd8,  5'd0,  16'h0001, CLS_ALU, 1'b1, 5'd0,  2'b10};
        rows[8]  = '{ENC_ALU_RR, 5'd9,  5'd1,  16'h1000, CLS_ALU, 1'b1, 5'd2,  2'b11};
        rows[9]  = '{ENC_MUL,    5'd10, 5'd9,  16'h2000, CLS_MUL, 1'b1, 5'd4,  2'b11};
        rows[10] = '{ENC_LOAD,   5'd11, 5'd2,  16'h0008, CLS_MEM, 1'b1, 5'd0,  2'b10};
        rows[11] = '{ENC_ALU_RR, 5'd12, 5'd11, 16'h3000, CLS_ALU, 1'b1, 5'd6,  2'b11};
        rows[12] = '{ENC_STORE,  5'd12, 5'd3,  16'h0010, CLS_MEM, 1'b0, 5'd12, 2'b11};
        rows[13] = '{ENC_MUL,    5'd13, 5'd4,  16'h2800, CLS_MUL, 1'b1, 5'd5,  2'b11};
        rows[14] = '{ENC_BRANCH, 5'd1,  5'd13, 16'h0020, CLS_BR,  1'b0, 5'd1,  2'b11};
        rows[15] = '{ENC_ALU_RI, 5'd14, 5'd0,  16'habcd, CLS_ALU, 1'b1, 5'd21, 2'b10};
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic core_pkg::issue_t expected_issue(input int idx);
        core_pkg::issue_t e;
        e          = '0;
        e.valid    = 1'b1;
        e.op_class = rows[idx].op_class;
        e.pc       = PC_BASE + 32'(idx * 4);
        e.rd       = rows[idx].rd;
        e.rd_we    = rows[idx].rd_we;
        e.rj       = rows[idx].rj;
        e.rk       = rows[idx].rk;
        e.imm      = rows[idx].imm;
        return e;
    endfunction

    task automatic check_issue(input core_pkg::issue_t got, input core_pkg::issue_t exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "issue packet mismatch");
        end
    endtask

    task automatic check_mask(input logic [W-1:0] got, input logic [W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "lane mask mismatch");
        end
    endtask

    task automatic flag_error(input string what);
        $display("Fail %0t: %s", $time, what);
        $display("sim failed");
        $fatal(1, "issue group rule broken");
    endtask

    task automatic give_up(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "timeout");
    endtask

    task automatic check_idle(input string what);
        logic [W-1:0] vld;
        for (int j = 0; j < W; j++) begin
            vld[j] = issue_o[j].valid;
        end
        check_mask(vld, '0, what);
        check_mask(accept_o, '0, what);
    endtask

    // Packet produced by the last edge is judged against the queued rows
    task automatic check_packet();
        logic [W-1:0] vld;
        logic [W-1:0] prefix;
        int           pkt_row [W];
        int           n;
        int           mem_cnt;
        int           mul_cnt;
        logic         rdy;
        n       = 0;
        mem_cnt = 0;
        mul_cnt = 0;
        for (int j = 0; j < W; j++) begin
            vld[j] = issue_o[j].valid;
            n      = n + (issue_o[j].valid ? 1 : 0);
        end
        for (int j = 0; j < W; j++) begin
            prefix[j] = (j < n);
        end
        if (prev_flush) begin
            check_mask(vld, '0, "issue lanes valid after flush");
        end else if (prev_stall) begin
            for (int j = 0; j < W; j++) begin
                check_issue(issue_o[j], prev_issue[j], "issue lane changed under stall");
            end
        end else begin
            check_mask(vld, prefix, "issue lanes not compacted");
            for (int j = 0; j < n; j++) begin
                if (pending.size() == 0) begin
                    flag_error("issue with no accepted instruction left");
                end
                pkt_row[j] = pending.pop_front();
                check_issue(issue_o[j], expected_issue(pkt_row[j]), "issue lane contents");
                case (issue_o[j].op_class)
                    core_pkg::OP_MUL: rdy = prev_mul_rdy;
                    core_pkg::OP_MEM: rdy = prev_mem_rdy;
                    default:          rdy = prev_alu_rdy;
                endcase
                if (!rdy) begin
                    flag_error("issued while its port was not ready");
                end
                if (issue_o[j].op_class == core_pkg::OP_MEM) mem_cnt++;
                if (issue_o[j].op_class == core_pkg::OP_MUL) mul_cnt++;
                if (issue_o[j].op_class == core_pkg::OP_BRANCH && j != n - 1) begin
                    flag_error("branch is not the last lane of its packet");
                end
                for (int m = 0; m < j; m++) begin
                    if (issue_o[m].rd_we &&
                        ((rows[pkt_row[j]].src_use[1] && issue_o[j].rj == issue_o[m].rd) ||
                         (rows[pkt_row[j]].src_use[0] && issue_o[j].rk == issue_o[m].rd))) begin
                        flag_error("lane reads a register written earlier in its packet");
                    end
                end
                issued_cnt++;
            end
            if (mem_cnt > 1 || mul_cnt > 1) begin
                flag_error("more than one MEM or MUL in a packet");
            end
        end
    endtask

    // Accepted lanes go to the model queue and fetch moves past them
    task automatic observe_accept();
        logic [W-1:0] lane_vld;
        logic [W-1:0] prefix;
        int           n_acc;
        n_acc = 0;
        for (int j = 0; j < W; j++) begin
            lane_vld[j] = fetch_i[j].valid;
            n_acc       = n_acc + (accept_o[j] ? 1 : 0);
        end
        for (int j = 0; j < W; j++) begin
            prefix[j] = (j < n_acc);
        end
        if (stall_i || flush_i) begin
            check_mask(accept_o, '0, "accept raised under stall or flush");
        end
        check_mask(accept_o & ~lane_vld, '0, "accept raised on an invalid lane");
        check_mask(accept_o, prefix, "accepted lanes are not a prefix");
        for (int j = 0; j < n_acc; j++) begin
            pending.push_back(lane_row[j]);
        end
        if (flush_i) begin
            // Refetch from the oldest instruction the flush throws away
            if (pending.size() > 0) begin
                fetch_ptr = pending[0];
            end
            pending.delete();
        end else begin
            fetch_ptr = fetch_ptr + n_acc;
        end
    endtask

    task automatic save_prev();
        prev_issue   = issue_o;
        prev_stall   = stall_i;
        prev_flush   = flush_i;
        prev_alu_rdy = alu_ready_i;
        prev_mul_rdy = mul_ready_i;
        prev_mem_rdy = mem_ready_i;
    endtask

    task automatic drive_controls(input int cyc);
        logic b0;
        logic b1;
        logic b2;
        if (cyc < RANDOM_CYCLES) begin
            take_bit(b0);
            take_bit(b1);
            alu_ready_i <= b0 | b1;
            take_bit(b0);
            take_bit(b1);
            mul_ready_i <= b0 | b1;
            take_bit(b0);
            take_bit(b1);
            mem_ready_i <= b0 | b1;
            take_bit(b0);
            take_bit(b1);
            take_bit(b2);
            stall_i <= b0 & b1 & b2;
            flush_i <= (cyc == 15) || (cyc == 33);
        end else begin
            // Everything ready so the table drains
            alu_ready_i <= 1'b1;
            mul_ready_i <= 1'b1;
            mem_ready_i <= 1'b1;
            stall_i     <= 1'b0;
            flush_i     <= 1'b0;
        end
    endtask

    task automatic drive_fetch();
        core_pkg::instr_info_t lane;
        int                    idx;
        for (int j = 0; j < W; j++) begin
            idx         = fetch_ptr + j;
            lane_row[j] = idx;
            lane        = '0;
            if (idx < NUM_ROWS) begin
                lane.valid = 1'b1;
                lane.pc    = PC_BASE + 32'(idx * 4);
                lane.instr = {rows[idx].opc, rows[idx].rd, rows[idx].rj, rows[idx].imm};
            end
            fetch_i[j] <= lane;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        drive_controls(cycle);
        drive_fetch();
        @(negedge clk);
        check_packet();
        observe_accept();
        save_prev();
        cycle++;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        alu_ready_i = 1'b1;
        mul_ready_i = 1'b1;
        mem_ready_i = 1'b1;
        fetch_i     = '0;
        lfsr        = LFSR_SEED;
        fetch_ptr   = 0;
        issued_cnt  = 0;
        cycle       = 0;
        load_table();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_idle("outputs active during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("outputs active right after reset");
        save_prev();

        while (issued_cnt < NUM_ROWS) begin
            if (cycle >= RUN_TIMEOUT) begin
                give_up("timed out waiting for every table row to issue");
            end
            run_cycle();
        end
        // A few idle cycles in which nothing more may issue
        repeat (DRAIN_CYCLES) begin
            run_cycle();
        end

        if (issued_cnt == NUM_ROWS && pending.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("not every table row issued exactly once");
            $display("sim failed");
            $fatal(1, "incomplete run");
        end
    end

endmodule

// File: sources.f
verilog/core_pkg.sv
verilog/instr_decoder.sv
verilog/id_dispatch.sv
verilog/dispatch_unit.sv
verilog/decode_dispatch_top.sv
dv/tb_decode_dispatch.sv

// File: verilog/core_pkg.sv
package core_pkg;

    // Machine widths
    localparam int DECODE_WIDTH  = 2;
    localparam int ADDR_WIDTH    = 32;
    localparam int INSTR_WIDTH   = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int IMM_WIDTH     = 16;
    localparam int OPCODE_WIDTH  = 6;

    // Wide enough to count 0..DECODE_WIDTH slots
    localparam int CNT_WIDTH = $clog2(DECODE_WIDTH + 1);

    // Instruction word layout
    localparam int OPCODE_LSB = 26;
    localparam int RD_LSB     = 21;
    localparam int RJ_LSB     = 16;
    localparam int RK_LSB     = 11;

    // Major opcodes in bits 31:26
    localparam logic [OPCODE_WIDTH-1:0] OPC_ALU_RR = 6'h01;
    localparam logic [OPCODE_WIDTH-1:0] OPC_ALU_RI = 6'h09;
    localparam logic [OPCODE_WIDTH-1:0] OPC_MUL    = 6'h0c;
    localparam logic [OPCODE_WIDTH-1:0] OPC_LOAD   = 6'h23;
    localparam logic [OPCODE_WIDTH-1:0] OPC_STORE  = 6'h2b;
    localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH = 6'h04;

    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_MUL    = 2'd1,
        OP_MEM    = 2'd2,
        OP_BRANCH = 2'd3
    } op_class_e;

    // One fetch lane as delivered by fetch
    typedef struct packed {
        logic                   valid;
        logic [ADDR_WIDTH-1:0]  pc;
        logic [INSTR_WIDTH-1:0] instr;
    } instr_info_t;

    // Decoded record held in the dispatch buffer
    typedef struct packed {
        instr_info_t              instr_info;
        op_class_e                op_class;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic                     rd_we;
        logic [REG_IDX_WIDTH-1:0] rj;
        logic                     rj_use;
        logic [REG_IDX_WIDTH-1:0] rk;
        logic                     rk_use;
        logic [IMM_WIDTH-1:0]     imm;
    } id_dispatch_t;

    // What an execution port receives
    typedef struct packed {
        logic                     valid;
        op_class_e                op_class;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic                     rd_we;
        logic [REG_IDX_WIDTH-1:0] rj;
        logic [REG_IDX_WIDTH-1:0] rk;
        logic [IMM_WIDTH-1:0]     imm;
    } issue_t;

endpackage

// File: verilog/decode_dispatch_top.sv
`timescale 1ns/1ps

module decode_dispatch_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                stall_i,
    input  logic                                                flush_i,
    input  core_pkg::instr_info_t [core_pkg::DECODE_WIDTH-1:0] fetch_i,
    output logic                  [core_pkg::DECODE_WIDTH-1:0] accept_o,
    input  logic                                                alu_ready_i,
    input  logic                                                mul_ready_i,
    input  logic                                                mem_ready_i,
    output core_pkg::issue_t      [core_pkg::DECODE_WIDTH-1:0] issue_o
);

    core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] id_lanes;
    core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] slots;
    logic                   [core_pkg::DECODE_WIDTH-1:0] issue_mask;

    instr_decoder u_decoder (
        .fetch_i (fetch_i),
        .id_o    (id_lanes)
    );

    // Shifting buffer between decode and dispatch
    id_dispatch u_id_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .id_i         (id_lanes),
        .accept_o     (accept_o),
        .issue_mask_i (issue_mask),
        .dispatch_o   (slots)
    );

    dispatch_unit u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .slots_i      (slots),
        .alu_ready_i  (alu_ready_i),
        .mul_ready_i  (mul_ready_i),
        .mem_ready_i  (mem_ready_i),
        .issue_mask_o (issue_mask),
        .issue_o      (issue_o)
    );

endmodule

// File: verilog/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 stall_i,
    input  logic                                                 flush_i,
    input  core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] slots_i,
    input  logic                                                 alu_ready_i,
    input  logic                                                 mul_ready_i,
    input  logic                                                 mem_ready_i,
    output logic                   [core_pkg::DECODE_WIDTH-1:0] issue_mask_o,
    output core_pkg::issue_t       [core_pkg::DECODE_WIDTH-1:0] issue_o
);

    logic [core_pkg::DECODE_WIDTH-1:0]        issue_sel;
    core_pkg::issue_t [core_pkg::DECODE_WIDTH-1:0] issue_next;
    logic [core_pkg::DECODE_WIDTH-1:0]        issue_vld;
    logic [core_pkg::DECODE_WIDTH-1:0]        mem_lane;

    logic blocked;
    logic ok;
    logic has_mem;
    logic has_mul;
    logic has_branch;

    // Group grows slot by slot until the first valid slot that cannot go
    always_comb begin
        issue_mask_o = '0;
        issue_sel    = '0;
        blocked      = 1'b0;
        ok           = 1'b0;
        has_mem      = 1'b0;
        has_mul      = 1'b0;
        has_branch   = 1'b0;
        for (int k = 0; k < core_pkg::DECODE_WIDTH; k++) begin
            if (!blocked) begin
                if (!slots_i[k].instr_info.valid) begin
                    // Bubble, freed without issuing
                    issue_mask_o[k] = 1'b1;
                end else begin
                    case (slots_i[k].op_class)
                        core_pkg::OP_MUL: ok = mul_ready_i && !has_mul;
                        core_pkg::OP_MEM: ok = mem_ready_i && !has_mem;
                        default:          ok = alu_ready_i;
                    endcase
                    if (has_branch) ok = 1'b0;
                    // RAW against earlier members of this group
                    for (int j = 0; j < k; j++) begin
                        if (issue_sel[j] && slots_i[j].rd_we) begin
                            if (slots_i[k].rj_use && slots_i[k].rj == slots_i[j].rd) ok = 1'b0;
                            if (slots_i[k].rk_use && slots_i[k].rk == slots_i[j].rd) ok = 1'b0;
                        end
                    end
                    if (ok) begin
                        issue_sel[k]    = 1'b1;
                        issue_mask_o[k] = 1'b1;
                        has_mem    = has_mem || (slots_i[k].op_class == core_pkg::OP_MEM);
                        has_mul    = has_mul || (slots_i[k].op_class == core_pkg::OP_MUL);
                        has_branch = slots_i[k].op_class == core_pkg::OP_BRANCH;
                    end else begin
                        blocked = 1'b1;
                    end
                end
            end
        end
        // Nothing leaves the buffer while held or flushed
        if (stall_i || flush_i) begin
            issue_mask_o = '0;
            issue_sel    = '0;
        end
    end

    // Compact selected slots into the low lanes, program order kept
    always_comb begin
        int lane;
        lane       = 0;
        issue_next = '0;
        for (int k = 0; k < core_pkg::DECODE_WIDTH; k++) begin
            if (issue_sel[k]) begin
                issue_next[lane].valid    = 1'b1;
                issue_next[lane].op_class = slots_i[k].op_class;
                issue_next[lane].pc       = slots_i[k].instr_info.pc;
                issue_next[lane].rd       = slots_i[k].rd;
                issue_next[lane].rd_we    = slots_i[k].rd_we;
                issue_next[lane].rj       = slots_i[k].rj;
                issue_next[lane].rk       = slots_i[k].rk;
                issue_next[lane].imm      = slots_i[k].imm;
                lane = lane + 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_o <= '0;
        end else if (flush_i) begin
            issue_o <= '0;
        end else if (!stall_i) begin
            issue_o <= issue_next;
        end
    end

    always_comb begin
        for (int j = 0; j < core_pkg::DECODE_WIDTH; j++) begin
            issue_vld[j] = issue_o[j].valid;
            mem_lane[j]  = issue_o[j].valid && (issue_o[j].op_class == core_pkg::OP_MEM);
        end
    end

    a_one_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(mem_lane)
    ) else $error("more than one MEM op in the issue packet");

    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_i |=> (issue_vld == '0)
    ) else $error("issue packet still valid after flush");

endmodule

// File: verilog/id_dispatch.sv
`timescale 1ns/1ps

module id_dispatch (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 stall_i,
    input  logic                                                 flush_i,
    input  core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] id_i,
    output logic                   [core_pkg::DECODE_WIDTH-1:0] accept_o,
    input  logic                   [core_pkg::DECODE_WIDTH-1:0] issue_mask_i,
    output core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] dispatch_o
);

    logic [core_pkg::CNT_WIDTH-1:0]    free_cnt;
    logic [core_pkg::CNT_WIDTH-1:0]    keep_cnt;
    logic [core_pkg::DECODE_WIDTH-1:0] lane_vld;

    // Freed slots leave the head, survivors stay
    always_comb begin
        free_cnt = '0;
        keep_cnt = '0;
        for (int i = 0; i < core_pkg::DECODE_WIDTH; i++) begin
            free_cnt = free_cnt + issue_mask_i[i];
            keep_cnt = keep_cnt + !issue_mask_i[i];
        end
    end

    // Lane i fits if a freed slot is left for it
    always_comb begin
        for (int i = 0; i < core_pkg::DECODE_WIDTH; i++) begin
            lane_vld[i] = id_i[i].instr_info.valid;
            accept_o[i] = lane_vld[i] && (i < free_cnt);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dispatch_o <= '0;
        end else if (flush_i) begin
            dispatch_o <= '0;
        end else if (!stall_i) begin
            for (int i = 0; i < core_pkg::DECODE_WIDTH; i++) begin
                if (i < keep_cnt) begin
                    dispatch_o[i] <= dispatch_o[i + free_cnt];
                end else begin
                    // Tail refill in lane order, bubbles stay invalid
                    dispatch_o[i] <= id_i[i - keep_cnt];
                end
            end
        end
    end

    // Dispatch may only free a contiguous run from the head
    a_mask_prefix: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_mask_i & (issue_mask_i + 1'b1)) == '0
    ) else $error("issue mask from dispatch is not a prefix");

    a_accept_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (accept_o & ~lane_vld) == '0
    ) else $error("accept raised on an invalid decode lane");

endmodule

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  core_pkg::instr_info_t  [core_pkg::DECODE_WIDTH-1:0] fetch_i,
    output core_pkg::id_dispatch_t [core_pkg::DECODE_WIDTH-1:0] id_o
);

    logic [core_pkg::INSTR_WIDTH-1:0]   word;
    logic [core_pkg::OPCODE_WIDTH-1:0]  opcode;
    logic [core_pkg::REG_IDX_WIDTH-1:0] rd_field;
    logic                               known;

    // Each lane decoded on its own, no cross-lane dependency
    always_comb begin
        word     = '0;
        opcode   = '0;
        rd_field = '0;
        known    = 1'b0;
        for (int i = 0; i < core_pkg::DECODE_WIDTH; i++) begin
            word     = fetch_i[i].instr;
            opcode   = word[core_pkg::OPCODE_LSB +: core_pkg::OPCODE_WIDTH];
            rd_field = word[core_pkg::RD_LSB +: core_pkg::REG_IDX_WIDTH];
            known    = 1'b1;

            id_o[i]            = '0;
            id_o[i].instr_info = fetch_i[i];
            id_o[i].op_class   = core_pkg::OP_ALU;
            id_o[i].rd         = rd_field;
            id_o[i].rj         = word[core_pkg::RJ_LSB +: core_pkg::REG_IDX_WIDTH];
            id_o[i].rk         = word[core_pkg::RK_LSB +: core_pkg::REG_IDX_WIDTH];
            id_o[i].imm        = word[core_pkg::IMM_WIDTH-1:0];

            case (opcode)
                core_pkg::OPC_ALU_RR: begin
                    id_o[i].op_class = core_pkg::OP_ALU;
                    id_o[i].rd_we    = 1'b1;
                    id_o[i].rj_use   = 1'b1;
                    id_o[i].rk_use   = 1'b1;
                end
                core_pkg::OPC_ALU_RI: begin
                    id_o[i].op_class = core_pkg::OP_ALU;
                    id_o[i].rd_we    = 1'b1;
                    id_o[i].rj_use   = 1'b1;
                end
                core_pkg::OPC_MUL: begin
                    id_o[i].op_class = core_pkg::OP_MUL;
                    id_o[i].rd_we    = 1'b1;
                    id_o[i].rj_use   = 1'b1;
                    id_o[i].rk_use   = 1'b1;
                end
                core_pkg::OPC_LOAD: begin
                    id_o[i].op_class = core_pkg::OP_MEM;
                    id_o[i].rd_we    = 1'b1;
                    id_o[i].rj_use   = 1'b1;
                end
                core_pkg::OPC_STORE: begin
                    // Store data comes from the rd field, read through rk
                    id_o[i].op_class = core_pkg::OP_MEM;
                    id_o[i].rj_use   = 1'b1;
                    id_o[i].rk       = rd_field;
                    id_o[i].rk_use   = 1'b1;
                end
                core_pkg::OPC_BRANCH: begin
                    // Compares rj with the rd field, writes nothing
                    id_o[i].op_class = core_pkg::OP_BRANCH;
                    id_o[i].rj_use   = 1'b1;
                    id_o[i].rk       = rd_field;
                    id_o[i].rk_use   = 1'b1;
                end
                default: begin
                    known = 1'b0;
                end
            endcase

            // Unknown opcode turns the lane into a bubble
            id_o[i].instr_info.valid = fetch_i[i].valid & known;
        end
    end

endmodule
